// ==== fc_pkg.sv ====
package fc_pkg;

  // ==============================
  // core grouping
  // ==============================

  // cores working on one output group
  localparam int CORE    = 4;
  localparam int CORELOG = 2;

  // ==============================
  // data widths
  // ==============================

  localparam int DWIDTH = 16;
  localparam int WWIDTH = 8;
  localparam int AWIDTH = 32;
  // fixed point position of the weights
  localparam int WFRAC  = 4;

  // ==============================
  // address and size widths
  // ==============================

  localparam int IMGSIZE = 10;
  localparam int NETSIZE = 10;
  localparam int LWIDTH  = 10;

  // ==============================
  // word types
  // ==============================

  typedef logic signed [DWIDTH-1:0] act_t;
  typedef logic signed [WWIDTH-1:0] wgt_t;
  typedef logic signed [AWIDTH-1:0] acc_t;

  // saturation bounds of an activation, in accumulator width
  localparam acc_t ACT_MAX = (2 ** (DWIDTH - 1)) - 1;
  localparam acc_t ACT_MIN = -(2 ** (DWIDTH - 1));

  // stream control beside the data
  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } ctrl_t;

endpackage

// ==== fc_ram.sv ====
module fc_ram #(
  parameter type word_t = logic [15:0],
  parameter int  ADDR_W = 10
) (
  input  logic              clk,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  word_t             wdata,
  output word_t             rdata
);

  localparam int DEPTH = 1 << ADDR_W;

  word_t mem [0:DEPTH-1];

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // registered read, old data on a write to the same address
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

// ==== fc_core.sv ====
module fc_core import fc_pkg::*; (
  input  logic  clk,
  input  logic  xrst,
  input  act_t  x,
  input  wgt_t  w,
  input  ctrl_t ctrl,
  input  logic  breg_we,
  output act_t  result
);

  acc_t acc;
  acc_t sum;
  acc_t shifted;
  act_t sat;

  // bias beat adds w itself, other beats the product
  always_comb begin
    sum     = breg_we ? acc + w : acc + x * w;
    shifted = sum >>> WFRAC;
    if (shifted > ACT_MAX) begin
      sat = act_t'(ACT_MAX);
    end else if (shifted < ACT_MIN) begin
      sat = act_t'(ACT_MIN);
    end else begin
      sat = act_t'(shifted);
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      acc <= '0;
    end else if (ctrl.start) begin
      acc <= '0;
    end else if (ctrl.valid) begin
      acc <= sum;
    end
  end

  // result held until the next group's bias beat
  always_ff @(posedge clk) begin
    if (ctrl.valid && breg_we) begin
      result <= sat;
    end
  end

  assert property (@(posedge clk) disable iff (!xrst) breg_we |-> ctrl.stop)
    else $error("bias beat without stop");

endmodule

// ==== fc_core_array.sv ====
module fc_core_array import fc_pkg::*; (
  input  logic  clk,
  input  logic  xrst,
  input  act_t  x,
  input  wgt_t  w [CORE],
  input  ctrl_t core_ctrl,
  input  logic  breg_we,
  output act_t  results [CORE],
  output ctrl_t done_ctrl
);

  // ==============================
  // cores
  // ==============================

  // same input word, own weight stream per core
  for (genvar i = 0; i < CORE; i++) begin : g_core
    fc_core core_i (
      .clk     (clk),
      .xrst    (xrst),
      .x       (x),
      .w       (w[i]),
      .ctrl    (core_ctrl),
      .breg_we (breg_we),
      .result  (results[i])
    );
  end

  // ==============================
  // done control
  // ==============================

  // results are registered on the stop beat, so one stage later
  // they form a single beat stream
  always_ff @(posedge clk) begin
    if (!xrst) begin
      done_ctrl <= '0;
    end else begin
      done_ctrl.start <= core_ctrl.stop;
      done_ctrl.valid <= core_ctrl.stop && core_ctrl.valid;
      done_ctrl.stop  <= core_ctrl.stop;
    end
  end

endmodule

// ==== fc_serializer.sv ====
module fc_serializer import fc_pkg::*; (
  input  logic clk,
  input  logic xrst,
  input  logic load,
  input  act_t results [CORE],
  output act_t out_wdata
);

  act_t sreg [CORE];

  // word 0 goes out first
  assign out_wdata = sreg[0];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < CORE; i++) begin
        sreg[i] <= '0;
      end
    end else if (load) begin
      sreg <= results;
    end else begin
      for (int i = 0; i < CORE - 1; i++) begin
        sreg[i] <= sreg[i+1];
      end
      sreg[CORE-1] <= '0;
    end
  end

endmodule

// ==== img_arbiter.sv ====
module img_arbiter import fc_pkg::*; (
  input  logic               ack,
  input  logic               ctrl_we,
  input  logic [IMGSIZE-1:0] ctrl_addr,
  input  act_t               ctrl_wdata,
  input  logic               host_img_we,
  input  logic [IMGSIZE-1:0] host_img_addr,
  input  act_t               host_img_wdata,
  output logic               host_img_gnt,
  output logic               mem_we,
  output logic [IMGSIZE-1:0] mem_addr,
  output act_t               mem_wdata
);

  // host owns the memory whenever the layer is idle
  assign host_img_gnt = ack;

  // a host write without grant never reaches the memory
  assign mem_we    = (host_img_gnt && host_img_we) || (!host_img_gnt && ctrl_we);
  assign mem_addr  = host_img_gnt ? host_img_addr : ctrl_addr;
  assign mem_wdata = host_img_gnt ? host_img_wdata : ctrl_wdata;

  // controller writes only happen inside a busy layer
  always_comb begin
    assert #0 (ack !== 1'b1 || ctrl_we !== 1'b1)
      else $error("controller write while the host holds the image memory");
  end

endmodule

// ==== fc_ctrl.sv ====
module fc_ctrl import fc_pkg::*; (
  input  logic               clk,
  input  logic               xrst,
  input  logic               req,
  input  logic [CORELOG-1:0] net_sel,
  input  logic               net_we,
  input  logic [NETSIZE-1:0] net_addr,
  input  logic [IMGSIZE-1:0] in_offset,
  input  logic [IMGSIZE-1:0] out_offset,
  input  logic [LWIDTH-1:0]  total_in,
  input  logic [LWIDTH-1:0]  total_out,
  input  ctrl_t              done_ctrl,
  input  act_t               out_wdata,
  output logic               ack,
  output logic               mem_img_we,
  output logic [IMGSIZE-1:0] mem_img_addr,
  output act_t               mem_img_wdata,
  output logic [CORE-1:0]    mem_net_we,
  output logic [NETSIZE-1:0] mem_net_addr,
  output ctrl_t              core_ctrl,
  output logic               breg_we,
  output logic               serial_we
);

  typedef enum logic [1:0] {
    S_WAIT,
    S_WEIGHT,
    S_BIAS,
    S_OUTPUT
  } state_t;

  state_t             state;
  logic [LWIDTH-1:0]  tot_in;
  logic [LWIDTH-1:0]  tot_out;
  logic [LWIDTH-1:0]  count_in;
  logic [LWIDTH-1:0]  count_out;
  logic [LWIDTH:0]    next_out;
  logic [IMGSIZE-1:0] in_base;
  logic [IMGSIZE-1:0] out_base;
  logic [IMGSIZE-1:0] out_addr;
  logic [NETSIZE-1:0] net_base;
  logic [NETSIZE-1:0] net_run;
  logic [CORELOG:0]   serial_cnt;
  logic               accept;
  logic               weight_end;
  logic               output_end;
  logic               last_group;

  assign accept     = state == S_WAIT && req && ack;
  assign weight_end = state == S_WEIGHT && count_in == tot_in - 1'b1;
  assign output_end = state == S_OUTPUT && serial_cnt == (CORELOG + 1)'(CORE);
  assign next_out   = {1'b0, count_out} + (LWIDTH + 1)'(CORE);
  // no further group once this one covers total_out
  assign last_group = next_out >= {1'b0, tot_out};

  // ==============================
  // state machine
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= S_WAIT;
      count_in  <= '0;
      count_out <= '0;
    end else begin
      case (state)
        S_WAIT: begin
          if (accept) begin
            state     <= S_WEIGHT;
            count_in  <= '0;
            count_out <= '0;
          end
        end
        S_WEIGHT: begin
          if (weight_end) begin
            state    <= S_BIAS;
            count_in <= '0;
          end else begin
            count_in <= count_in + 1'b1;
          end
        end
        S_BIAS: begin
          state <= S_OUTPUT;
        end
        S_OUTPUT: begin
          if (output_end) begin
            if (last_group) begin
              state <= S_WAIT;
            end else begin
              state     <= S_WEIGHT;
              count_out <= next_out[LWIDTH-1:0];
            end
          end
        end
        default: begin
          state <= S_WAIT;
        end
      endcase
    end
  end

  // layer parameters held for the whole request
  always_ff @(posedge clk) begin
    if (accept) begin
      tot_in   <= total_in;
      tot_out  <= total_out;
      in_base  <= in_offset;
      out_base <= out_offset;
      net_base <= net_addr;
    end
  end

  // ==============================
  // image side
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_addr <= '0;
    end else if (accept) begin
      out_addr <= '0;
    end else if (mem_img_we) begin
      out_addr <= out_addr + 1'b1;
    end
  end

  assign mem_img_addr  = state == S_OUTPUT ? out_base + out_addr
                                           : in_base + IMGSIZE'(count_in);
  assign mem_img_wdata = state == S_OUTPUT ? out_wdata : '0;

  // four writes, one per serialized word
  always_ff @(posedge clk) begin
    if (!xrst) begin
      mem_img_we <= 1'b0;
    end else begin
      mem_img_we <= state == S_OUTPUT
                 && (serial_we || (serial_cnt != '0 && serial_cnt < (CORELOG + 1)'(CORE)));
    end
  end

  // ==============================
  // network side
  // ==============================

  // runs over weights and biases of all groups back to back
  always_ff @(posedge clk) begin
    if (!xrst) begin
      net_run <= '0;
    end else if (accept) begin
      net_run <= '0;
    end else if (state == S_WEIGHT || state == S_BIAS) begin
      net_run <= net_run + 1'b1;
    end
  end

  for (genvar i = 0; i < CORE; i++) begin : g_net_we
    assign mem_net_we[i] = net_we && net_sel == CORELOG'(i);
  end

  // host address while loading
  assign mem_net_addr = net_we ? net_addr : net_base + net_run;

  // ==============================
  // core and output control
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack        <= 1'b1;
      core_ctrl  <= '0;
      breg_we    <= 1'b0;
      serial_we  <= 1'b0;
      serial_cnt <= '0;
    end else begin
      if (accept) begin
        ack <= 1'b0;
      end else if (output_end && last_group) begin
        ack <= 1'b1;
      end
      // registered so they line up with the memory read data
      core_ctrl.start <= accept || (output_end && !last_group);
      core_ctrl.valid <= state == S_WEIGHT || state == S_BIAS;
      core_ctrl.stop  <= state == S_BIAS;
      breg_we         <= state == S_BIAS;
      serial_we       <= done_ctrl.start;
      if (serial_we) begin
        serial_cnt <= (CORELOG + 1)'(1);
      end else if (serial_cnt == (CORELOG + 1)'(CORE)) begin
        serial_cnt <= '0;
      end else if (serial_cnt != '0) begin
        serial_cnt <= serial_cnt + 1'b1;
      end
    end
  end

  // host must wait for ack before a new request or a weight load
  assert property (@(posedge clk) disable iff (!xrst) !ack |-> !$rose(req))
    else $error("req raised while the layer is busy");
  assert property (@(posedge clk) disable iff (!xrst) !ack |-> !net_we)
    else $error("network memory written while the layer is busy");

endmodule

// ==== fc_layer.sv ====
module fc_layer import fc_pkg::*; (
  input  logic               clk,
  input  logic               xrst,
  input  logic               req,
  input  logic [CORELOG-1:0] net_sel,
  input  logic               net_we,
  input  logic [NETSIZE-1:0] net_addr,
  input  wgt_t               net_wdata,
  input  logic [IMGSIZE-1:0] in_offset,
  input  logic [IMGSIZE-1:0] out_offset,
  input  logic [LWIDTH-1:0]  total_in,
  input  logic [LWIDTH-1:0]  total_out,
  input  logic               host_img_we,
  input  logic [IMGSIZE-1:0] host_img_addr,
  input  act_t               host_img_wdata,
  output logic               ack,
  output logic               host_img_gnt,
  output act_t               host_img_rdata
);

  logic               mem_img_we;
  logic [IMGSIZE-1:0] mem_img_addr;
  act_t               mem_img_wdata;
  logic               img_we;
  logic [IMGSIZE-1:0] img_addr;
  act_t               img_wdata;
  logic [CORE-1:0]    mem_net_we;
  logic [NETSIZE-1:0] mem_net_addr;
  wgt_t               net_rdata [CORE];
  act_t               results [CORE];
  act_t               out_wdata;
  ctrl_t              core_ctrl;
  ctrl_t              done_ctrl;
  logic               breg_we;
  logic               serial_we;

  fc_ctrl ctrl_i (
    .clk           (clk),
    .xrst          (xrst),
    .req           (req),
    .net_sel       (net_sel),
    .net_we        (net_we),
    .net_addr      (net_addr),
    .in_offset     (in_offset),
    .out_offset    (out_offset),
    .total_in      (total_in),
    .total_out     (total_out),
    .done_ctrl     (done_ctrl),
    .out_wdata     (out_wdata),
    .ack           (ack),
    .mem_img_we    (mem_img_we),
    .mem_img_addr  (mem_img_addr),
    .mem_img_wdata (mem_img_wdata),
    .mem_net_we    (mem_net_we),
    .mem_net_addr  (mem_net_addr),
    .core_ctrl     (core_ctrl),
    .breg_we       (breg_we),
    .serial_we     (serial_we)
  );

  // ==============================
  // image memory and its arbiter
  // ==============================

  img_arbiter arb_i (
    .ack            (ack),
    .ctrl_we        (mem_img_we),
    .ctrl_addr      (mem_img_addr),
    .ctrl_wdata     (mem_img_wdata),
    .host_img_we    (host_img_we),
    .host_img_addr  (host_img_addr),
    .host_img_wdata (host_img_wdata),
    .host_img_gnt   (host_img_gnt),
    .mem_we         (img_we),
    .mem_addr       (img_addr),
    .mem_wdata      (img_wdata)
  );

  // read data feeds both the host and the cores
  fc_ram #(.word_t(act_t), .ADDR_W(IMGSIZE)) img_ram_i (
    .clk   (clk),
    .we    (img_we),
    .addr  (img_addr),
    .wdata (img_wdata),
    .rdata (host_img_rdata)
  );

  // ==============================
  // network memories, one per core
  // ==============================

  for (genvar i = 0; i < CORE; i++) begin : g_net
    fc_ram #(.word_t(wgt_t), .ADDR_W(NETSIZE)) net_ram_i (
      .clk   (clk),
      .we    (mem_net_we[i]),
      .addr  (mem_net_addr),
      .wdata (net_wdata),
      .rdata (net_rdata[i])
    );
  end

  fc_core_array cores_i (
    .clk       (clk),
    .xrst      (xrst),
    .x         (host_img_rdata),
    .w         (net_rdata),
    .core_ctrl (core_ctrl),
    .breg_we   (breg_we),
    .results   (results),
    .done_ctrl (done_ctrl)
  );

  fc_serializer ser_i (
    .clk       (clk),
    .xrst      (xrst),
    .load      (serial_we),
    .results   (results),
    .out_wdata (out_wdata)
  );

endmodule

// ==== fc_clk_gen.sv ====
module fc_clk_gen (
  output logic clk,
  output logic xrst
);
  timeunit 1ns;
  timeprecision 100ps;

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // low over two rising edges, released between edges
  initial begin
    xrst = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
  end

endmodule

// ==== tb_fc_layer.sv ====
module tb_fc_layer import fc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int     ACK_LIMIT = 2000;
  localparam int     RST_LIMIT = 20;
  localparam longint SAT_MAX   = 2 ** (DWIDTH - 1) - 1;
  localparam longint SAT_MIN   = -(2 ** (DWIDTH - 1));

  logic               clk;
  logic               xrst;
  logic               req;
  logic [CORELOG-1:0] net_sel;
  logic               net_we;
  logic [NETSIZE-1:0] net_addr;
  wgt_t               net_wdata;
  logic [IMGSIZE-1:0] in_offset;
  logic [IMGSIZE-1:0] out_offset;
  logic [LWIDTH-1:0]  total_in;
  logic [LWIDTH-1:0]  total_out;
  logic               host_img_we;
  logic [IMGSIZE-1:0] host_img_addr;
  act_t               host_img_wdata;
  logic               ack;
  logic               host_img_gnt;
  act_t               host_img_rdata;

  // reference copies of the memories
  act_t        img_model [1 << IMGSIZE];
  wgt_t        net_model [CORE][1 << NETSIZE];
  logic [15:0] lfsr;
  int          errors;
  int          checks;

  fc_clk_gen clk_gen_i (
    .clk  (clk),
    .xrst (xrst)
  );

  fc_layer dut_i (.*);

  // ==============================
  // helpers
  // ==============================

  function automatic logic [15:0] galois_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = galois_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // neuron o = group * 4 + core
  function automatic act_t expected_out(int o, int tin, int inoff, int netoff);
    longint sum;
    longint shifted;
    int     core;
    int     base;
    core = o % CORE;
    base = netoff + (o / CORE) * (tin + 1);
    sum  = 0;
    for (int j = 0; j < tin; j++) begin
      sum += longint'(img_model[(inoff + j) % (1 << IMGSIZE)])
           * longint'(net_model[core][(base + j) % (1 << NETSIZE)]);
    end
    sum += longint'(net_model[core][(base + tin) % (1 << NETSIZE)]);
    shifted = sum >>> WFRAC;
    if (shifted > SAT_MAX) begin
      return act_t'(SAT_MAX);
    end else if (shifted < SAT_MIN) begin
      return act_t'(SAT_MIN);
    end
    return act_t'(shifted);
  endfunction

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (xrst !== 1'b1 && n < RST_LIMIT) begin
      next_cycle();
      n++;
    end
    if (xrst !== 1'b1) begin
      errors++;
      $display("reset was never released");
      finish_run();
    end
  endtask

  task automatic wait_ack_high();
    int n;
    n = 0;
    while (ack !== 1'b1 && n < ACK_LIMIT) begin
      next_cycle();
      n++;
    end
    if (ack !== 1'b1) begin
      errors++;
      $display("timeout: ack stayed low for %0d cycles", ACK_LIMIT);
      finish_run();
    end
  endtask

  task automatic host_write(input logic [IMGSIZE-1:0] addr, input act_t data);
    host_img_we    = 1'b1;
    host_img_addr  = addr;
    host_img_wdata = data;
    next_cycle();
    host_img_we     = 1'b0;
    img_model[addr] = data;
  endtask

  task automatic host_read(input logic [IMGSIZE-1:0] addr, output act_t data);
    host_img_addr = addr;
    next_cycle();
    data = host_img_rdata;
  endtask

  task automatic load_weight(input int core, input logic [NETSIZE-1:0] addr, input wgt_t data);
    net_we    = 1'b1;
    net_sel   = CORELOG'(core);
    net_addr  = addr;
    net_wdata = data;
    next_cycle();
    net_we                = 1'b0;
    net_model[core][addr] = data;
  endtask

  task automatic load_random(int tin, int groups, int inoff, int netoff);
    for (int j = 0; j < tin; j++) begin
      host_write(IMGSIZE'(inoff + j), act_t'(take_bits(DWIDTH)));
    end
    for (int g = 0; g < groups; g++) begin
      for (int i = 0; i < CORE; i++) begin
        for (int k = 0; k <= tin; k++) begin
          load_weight(i, NETSIZE'(netoff + g * (tin + 1) + k), wgt_t'(take_bits(WWIDTH)));
        end
      end
    end
  endtask

  task automatic start_layer(int tin, int tout, int inoff, int outoff, int netoff);
    total_in   = LWIDTH'(tin);
    total_out  = LWIDTH'(tout);
    in_offset  = IMGSIZE'(inoff);
    out_offset = IMGSIZE'(outoff);
    net_addr   = NETSIZE'(netoff);
    req        = 1'b1;
    next_cycle();
    req = 1'b0;
    if (ack !== 1'b0) begin
      errors++;
      $display("layer did not start, ack still high after req");
    end
  endtask

  // reads count words at outoff and updates the model
  task automatic check_outputs(int count, int tin, int inoff, int outoff, int netoff);
    act_t got;
    act_t exp;
    for (int o = 0; o < count; o++) begin
      exp = expected_out(o, tin, inoff, netoff);
      host_read(IMGSIZE'(outoff + o), got);
      checks++;
      if (got !== exp) begin
        errors++;
        $display("mismatch at %0d ns: output %0d got %0d expected %0d", $time, o, got, exp);
      end
      img_model[outoff + o] = exp;
    end
  endtask

  // ==============================
  // tests
  // ==============================

  task automatic test_reset_state();
    checks++;
    if (ack !== 1'b1 || host_img_gnt !== 1'b1) begin
      errors++;
      $display("mismatch at %0d ns: ack %b gnt %b after reset", $time, ack, host_img_gnt);
    end
  endtask

  task automatic test_host_access();
    act_t got;
    for (int k = 0; k < 16; k++) begin
      host_write(IMGSIZE'(10'h200 + k), act_t'(take_bits(DWIDTH)));
    end
    for (int k = 0; k < 16; k++) begin
      host_read(IMGSIZE'(10'h200 + k), got);
      checks++;
      if (got !== img_model[10'h200 + k]) begin
        errors++;
        $display("mismatch at %0d ns: image word %0d got %h expected %h",
                 $time, k, got, img_model[10'h200 + k]);
      end
    end
  endtask

  // small hand picked values
  task automatic test_single_group();
    for (int j = 0; j < 5; j++) begin
      host_write(IMGSIZE'(10'h010 + j), act_t'(60 * j - 100));
    end
    for (int i = 0; i < CORE; i++) begin
      for (int j = 0; j < 5; j++) begin
        load_weight(i, NETSIZE'(j), wgt_t'(3 * i + j - 4));
      end
      load_weight(i, NETSIZE'(5), wgt_t'(16 * i - 20));
    end
    start_layer(5, 4, 10'h010, 10'h040, 0);
    wait_ack_high();
    check_outputs(4, 5, 10'h010, 10'h040, 0);
  endtask

  task automatic test_multi_group();
    act_t got;
    int   sat;
    sat = 0;
    load_random(8, 3, 10'h123, 10'h050);
    for (int o = 0; o < 12; o++) begin
      got = expected_out(o, 8, 10'h123, 10'h050);
      if (got == act_t'(SAT_MAX) || got == act_t'(SAT_MIN)) begin
        sat++;
      end
    end
    if (sat == 0) begin
      errors++;
      $display("random data of the multi group test never saturates");
    end
    start_layer(8, 12, 10'h123, 10'h2a0, 10'h050);
    wait_ack_high();
    check_outputs(12, 8, 10'h123, 10'h2a0, 10'h050);
    // input region must be untouched
    for (int j = 0; j < 8; j++) begin
      host_read(IMGSIZE'(10'h123 + j), got);
      checks++;
      if (got !== img_model[10'h123 + j]) begin
        errors++;
        $display("mismatch at %0d ns: input %0d got %h expected %h",
                 $time, j, got, img_model[10'h123 + j]);
      end
    end
  endtask

  // last group still writes all four words
  task automatic test_partial_group();
    load_random(3, 2, 10'h300, 10'h100);
    for (int k = 0; k < 8; k++) begin
      host_write(IMGSIZE'(10'h310 + k), act_t'(16'h7e00 + k));
    end
    start_layer(3, 6, 10'h300, 10'h310, 10'h100);
    wait_ack_high();
    check_outputs(8, 3, 10'h300, 10'h310, 10'h100);
  endtask

  task automatic test_busy_drop();
    act_t got;
    host_write(10'h3f0, 16'h1234);
    start_layer(5, 4, 10'h010, 10'h040, 0);
    checks++;
    if (host_img_gnt !== 1'b0) begin
      errors++;
      $display("mismatch at %0d ns: host_img_gnt %b while busy", $time, host_img_gnt);
    end
    // write attempt without grant
    host_img_we    = 1'b1;
    host_img_addr  = 10'h3f0;
    host_img_wdata = 16'h4321;
    next_cycle();
    host_img_we = 1'b0;
    wait_ack_high();
    host_read(10'h3f0, got);
    checks++;
    if (got !== img_model[10'h3f0]) begin
      errors++;
      $display("mismatch at %0d ns: dropped write changed word to %h", $time, got);
    end
    check_outputs(4, 5, 10'h010, 10'h040, 0);
  endtask

  initial begin
    errors         = 0;
    checks         = 0;
    lfsr           = 16'd98;
    req            = 1'b0;
    net_sel        = '0;
    net_we         = 1'b0;
    net_addr       = '0;
    net_wdata      = '0;
    in_offset      = '0;
    out_offset     = '0;
    total_in       = '0;
    total_out      = '0;
    host_img_we    = 1'b0;
    host_img_addr  = '0;
    host_img_wdata = '0;
    wait_reset();
    test_reset_state();
    test_host_access();
    test_single_group();
    test_multi_group();
    test_partial_group();
    test_busy_drop();
    finish_run();
  end

endmodule

// ==== fc_layer.f ====
fc_pkg.sv
fc_ram.sv
fc_core.sv
fc_core_array.sv
fc_serializer.sv
img_arbiter.sv
fc_ctrl.sv
fc_layer.sv
fc_clk_gen.sv
tb_fc_layer.sv
